// ==== src.f ====
bp_pkg.sv
bht.sv
btb.sv
branch_resolve.sv
next_pc_select.sv
branch_predictor.sv
tb_branch_predictor.sv

// ==== tb_branch_predictor.sv ====
module tb_branch_predictor
  import bp_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic            clk;
  logic            reset;
  logic [pc_w-1:0] fetch_pc;
  logic            resolve_valid;
  resolve_t        resolve;
  logic [pc_w-1:0] next_pc;
  fetch_pred_t     pred;
  logic            redirect;
  logic [pc_w-1:0] redirect_pc;

  integer seed;                               // $random state.
  int     mismatches;                         // Wrong values seen.
  int     timeouts;                           // Waits that ran out.

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////
  logic            m_bht_valid [n_entries];
  logic [tag_w-1:0] m_bht_tag  [n_entries];
  counter_e        m_bht_ctr   [n_entries];
  logic            m_btb_valid [n_entries];
  logic [tag_w-1:0] m_btb_tag  [n_entries];
  logic [pc_w-1:0] m_btb_tgt   [n_entries];
  logic            pend_valid;                // Strobe driven this cycle.
  resolve_t        pend_res;
  logic            exp_redirect;              // Model redirect, one cycle late.
  logic [pc_w-1:0] exp_redirect_pc;
  fetch_pred_t     last_pred;                 // Record captured last cycle.
  fetch_pred_t     history[$];                // Recent DUT records for resolution.

  // Lookup PCs, with index aliases at 3, 7 and 1.
  logic [pc_w-1:0] pool [8] = '{16'h0123, 16'h0133, 16'h0457, 16'h0467,
                                16'h0a0c, 16'h00f1, 16'h01f1, 16'h0a0d};
  counter_e up_seq [4] = '{weak_t, strong_t, strong_t, strong_t};
  counter_e dn_seq [4] = '{weak_t, weak_nt, strong_nt, strong_nt};

  branch_predictor DUT (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .next_pc       (next_pc),
    .pred          (pred),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  always #50 clk = ~clk;                      // 100 ns period.

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Saturating step, written as arithmetic on the 2-bit code.
  function automatic counter_e step_ctr(counter_e c, logic tk);
    logic [1:0] v;
    v = c;
    if (tk && v != 2'd3) v = v + 2'd1;
    else if (!tk && v != 2'd0) v = v - 2'd1;
    return counter_e'(v);
  endfunction

  function automatic resolve_t make_resolve(fetch_pred_t p, logic tk, logic [pc_w-1:0] tg);
    resolve_t r;
    r.pred          = p;
    r.actual_taken  = tk;
    r.actual_target = tg;
    return r;
  endfunction

  function automatic fetch_pred_t model_predict(logic [pc_w-1:0] pc);
    fetch_pred_t p;
    logic [idx_w-1:0] idx;
    logic bhit;
    logic thit;
    idx  = pc[idx_w-1:0];
    bhit = m_bht_valid[idx] && (m_bht_tag[idx] == pc[pc_w-1:idx_w]);
    thit = m_btb_valid[idx] && (m_btb_tag[idx] == pc[pc_w-1:idx_w]);
    p.pc     = pc;
    p.ctr    = bhit ? m_bht_ctr[idx] : weak_nt;   // Miss reads weakly not taken.
    p.taken  = bhit && p.ctr[1] && thit;
    p.target = thit ? m_btb_tgt[idx] : pc + 16'd1;
    return p;
  endfunction

  // Applies the strobe of the cycle that just closed.
  task automatic model_commit();
    logic [idx_w-1:0] idx;
    exp_redirect = 1'b0;
    if (pend_valid) begin
      idx = pend_res.pred.pc[idx_w-1:0];
      m_bht_valid[idx] = 1'b1;
      m_bht_tag[idx]   = pend_res.pred.pc[pc_w-1:idx_w];
      m_bht_ctr[idx]   = step_ctr(pend_res.pred.ctr, pend_res.actual_taken);
      if (pend_res.actual_taken) begin
        m_btb_valid[idx] = 1'b1;
        m_btb_tag[idx]   = pend_res.pred.pc[pc_w-1:idx_w];
        m_btb_tgt[idx]   = pend_res.actual_target;
      end
      if (pend_res.pred.taken != pend_res.actual_taken) begin
        exp_redirect = 1'b1;                  // Wrong direction.
      end else if (pend_res.actual_taken) begin
        exp_redirect = (pend_res.pred.target != pend_res.actual_target);  // Wrong place.
      end
      exp_redirect_pc = pend_res.actual_taken ? pend_res.actual_target
                                              : pend_res.pred.pc + 16'd1;
    end
  endtask

  task automatic compare_outputs();
    fetch_pred_t exp;
    logic [pc_w-1:0] exp_next;
    exp = model_predict(fetch_pc);
    if (exp_redirect) exp_next = exp_redirect_pc;   // Redirect wins.
    else if (exp.taken) exp_next = exp.target;
    else exp_next = fetch_pc + 16'd1;
    compare("pred", pred, exp);
    compare("next_pc", next_pc, exp_next);
    compare("redirect", redirect, exp_redirect);
    if (exp_redirect) compare("redirect_pc", redirect_pc, exp_redirect_pc);
  endtask

  // One clock cycle: drive at the rising edge, check at the falling edge.
  task automatic run_cycle(input logic [pc_w-1:0] pc, input logic rv, input resolve_t res);
    @(posedge clk);
    model_commit();
    fetch_pc      <= pc;
    resolve_valid <= rv;
    resolve       <= res;
    pend_valid = rv;
    pend_res   = res;
    @(negedge clk);
    compare_outputs();
    last_pred = pred;
    history.push_back(pred);
    if (history.size() > 8) void'(history.pop_front());
  endtask

  task automatic wait_redirect(input int limit, output int waited);
    waited = 0;
    while (!redirect && waited < limit) begin
      run_cycle(16'h0a0c, 1'b0, '0);
      waited++;
    end
    if (!redirect) begin
      timeouts++;
      $display("Timeout: no redirect within %0d cycles at %0t", limit, $time);
    end
  endtask

  initial begin
    fetch_pred_t c_pred;
    logic [pc_w-1:0] pc;
    logic rv;
    resolve_t res;
    int waited;
    clk           = 1'b0;
    reset         = 1'b1;
    fetch_pc      = '0;
    resolve_valid = 1'b0;
    resolve       = '0;
    seed          = 32'h1b51_33dc;
    mismatches    = 0;
    timeouts      = 0;
    pend_valid    = 1'b0;
    pend_res      = '0;
    for (int i = 0; i < n_entries; i++) begin
      m_bht_valid[i] = 1'b0;                  // Model starts empty too.
      m_btb_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    //////////////////////////////////////// Empty tables.
    for (int i = 0; i < 8; i++) begin
      run_cycle(pool[i], 1'b0, '0);
      compare("pred.taken", pred.taken, 1'b0);
      compare("pred.ctr", pred.ctr, weak_nt);
      compare("next_pc", next_pc, pool[i] + 16'd1);
      compare("redirect", redirect, 1'b0);
    end

    //////////////////////////////////////// Counter training.
    run_cycle(pool[0], 1'b0, '0);
    for (int i = 0; i < 4; i++) begin
      run_cycle(pool[0], 1'b1, make_resolve(last_pred, 1'b1, 16'h0300));
      run_cycle(pool[0], 1'b0, '0);
      compare("pred.ctr", pred.ctr, up_seq[i]);
    end
    for (int i = 0; i < 4; i++) begin
      run_cycle(pool[0], 1'b1, make_resolve(last_pred, 1'b0, 16'h0000));
      run_cycle(pool[0], 1'b0, '0);
      compare("pred.ctr", pred.ctr, dn_seq[i]);
    end

    //////////////////////////////////////// Aliasing.
    run_cycle(pool[1], 1'b0, '0);             // Same index as pool[0].
    compare("pred.ctr", pred.ctr, weak_nt);
    compare("pred.taken", pred.taken, 1'b0);
    run_cycle(pool[1], 1'b1, make_resolve(last_pred, 1'b0, 16'h0000));
    run_cycle(pool[0], 1'b0, '0);             // First entry is gone.
    compare("pred.ctr", pred.ctr, weak_nt);
    compare("pred.taken", pred.taken, 1'b0);

    //////////////////////////////////////// Target prediction.
    run_cycle(pool[2], 1'b0, '0);
    run_cycle(pool[2], 1'b1, make_resolve(last_pred, 1'b1, 16'h0777));
    run_cycle(16'h0a0c, 1'b0, '0);            // Lets the redirect pass.
    run_cycle(pool[2], 1'b0, '0);
    compare("pred.taken", pred.taken, 1'b1);
    compare("next_pc", next_pc, 16'h0777);
    c_pred = pred;

    //////////////////////////////////////// Mispredictions.
    run_cycle(16'h0a0c, 1'b1, make_resolve(c_pred, 1'b1, 16'h0777));
    run_cycle(16'h0a0c, 1'b0, '0);
    compare("redirect", redirect, 1'b0);      // Correct prediction.
    run_cycle(16'h0a0c, 1'b1, make_resolve(c_pred, 1'b0, 16'h0000));
    wait_redirect(4, waited);
    compare("redirect latency", waited, 1);
    compare("redirect_pc", redirect_pc, pool[2] + 16'd1);
    compare("next_pc", next_pc, pool[2] + 16'd1);
    run_cycle(16'h0a0c, 1'b1, make_resolve(c_pred, 1'b1, 16'h077c));
    wait_redirect(4, waited);
    compare("redirect latency", waited, 1);
    compare("redirect_pc", redirect_pc, 16'h077c);
    compare("next_pc", next_pc, 16'h077c);

    //////////////////////////////////////// Random mix.
    for (int i = 0; i < 400; i++) begin
      pc = pool[$unsigned($random(seed)) % 8];
      rv = $random(seed) & 1;
      res = '0;
      if (rv && history.size() > 0) begin
        c_pred = history[$unsigned($random(seed)) % history.size()];
        res = make_resolve(c_pred, $random(seed) & 1,
                           (($random(seed) & 3) == 0) ? 16'($random(seed)) : c_pred.target);
      end else begin
        rv = 1'b0;
      end
      run_cycle(pc, rv, res);
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== branch_predictor.sv ====
module branch_predictor
  import bp_pkg::*;
(
  input  logic            clk,                // System clock.
  input  logic            reset,              // Sync reset, active high.
  input  logic [pc_w-1:0] fetch_pc,           // Current fetch PC.
  input  logic            resolve_valid,      // One-cycle resolution strobe.
  input  resolve_t        resolve,            // Carried record plus real outcome.
  output logic [pc_w-1:0] next_pc,            // PC to fetch next cycle.
  output fetch_pred_t     pred,               // Record sent down the pipe.
  output logic            redirect,           // One-cycle redirect pulse.
  output logic [pc_w-1:0] redirect_pc         // Corrected fetch PC.
);

  logic            bht_hit;
  counter_e        bht_ctr;
  logic            btb_hit;
  logic [pc_w-1:0] btb_target;
  logic            bht_we;
  bht_upd_t        bht_upd;
  logic            btb_we;
  btb_upd_t        btb_upd;

  bht u_bht (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .we        (bht_we),
    .upd       (bht_upd),
    .hit       (bht_hit),
    .ctr       (bht_ctr)
  );

  btb u_btb (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .we        (btb_we),
    .upd       (btb_upd),
    .hit       (btb_hit),
    .target    (btb_target)
  );

  branch_resolve u_resolve (
    .clk           (clk),
    .reset         (reset),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .bht_we        (bht_we),
    .bht_upd       (bht_upd),
    .btb_we        (btb_we),
    .btb_upd       (btb_upd),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  next_pc_select u_select (
    .fetch_pc    (fetch_pc),
    .bht_hit     (bht_hit),
    .bht_ctr     (bht_ctr),
    .btb_hit     (btb_hit),
    .btb_target  (btb_target),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .next_pc     (next_pc),
    .pred        (pred)
  );

endmodule

// ==== next_pc_select.sv ====
module next_pc_select
  import bp_pkg::*;
(
  input  logic [pc_w-1:0] fetch_pc,           // Current fetch PC.
  input  logic            bht_hit,            // BHT tag matched.
  input  counter_e        bht_ctr,            // BHT counter or ctr_miss.
  input  logic            btb_hit,            // BTB tag matched.
  input  logic [pc_w-1:0] btb_target,         // BTB target.
  input  logic            redirect,           // Redirect from resolution.
  input  logic [pc_w-1:0] redirect_pc,        // Corrected PC.
  output logic [pc_w-1:0] next_pc,            // PC to fetch next cycle.
  output fetch_pred_t     pred                // Record sent down the pipe.
);

  logic            taken;                     // Predicted direction.
  logic [pc_w-1:0] target;                    // Predicted next PC.

  ////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////
  // Taken needs a BHT hit with a taken counter and a BTB hit.
  assign taken  = bht_hit && bht_ctr[1] && btb_hit;
  assign target = btb_hit ? btb_target : fetch_pc + 16'd1;  // Fall through on a miss.

  assign pred = '{pc: fetch_pc, ctr: bht_ctr, taken: taken, target: target};

  ////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////
  always_comb begin
    if (redirect)   next_pc = redirect_pc;    // Resolution overrides the prediction.
    else if (taken) next_pc = target;
    else            next_pc = fetch_pc + 16'd1;
  end

endmodule

// ==== branch_resolve.sv ====
module branch_resolve
  import bp_pkg::*;
(
  input  logic     clk,                       // System clock.
  input  logic     reset,                     // Sync reset, active high.
  input  logic     resolve_valid,             // One-cycle resolution strobe.
  input  resolve_t resolve,                   // Carried record plus real outcome.
  output logic     bht_we,                    // BHT write, every resolution.
  output bht_upd_t bht_upd,                   // BHT write data.
  output logic     btb_we,                    // BTB write, taken only.
  output btb_upd_t btb_upd,                   // BTB write data.
  output logic     redirect,                  // One-cycle redirect pulse.
  output logic [pc_w-1:0] redirect_pc         // Corrected fetch PC.
);

  counter_e        next_ctr;                  // Trained counter.
  logic            mispredict;                // Outcome or target was wrong.
  logic [pc_w-1:0] corrected_pc;              // Where fetch should have gone.

  ////////////////////////////////////////
  // Saturating counter step
  ////////////////////////////////////////
  always_comb begin
    next_ctr = resolve.pred.ctr;              // Hold by default.
    case (resolve.pred.ctr)
      strong_nt: next_ctr = resolve.actual_taken ? weak_nt  : strong_nt;
      weak_nt:   next_ctr = resolve.actual_taken ? weak_t   : strong_nt;
      weak_t:    next_ctr = resolve.actual_taken ? strong_t : weak_nt;
      strong_t:  next_ctr = resolve.actual_taken ? strong_t : weak_t;  // Drop to weak.
    endcase
  end

  // Wrong direction, or taken both ways but to a different place.
  assign mispredict = (resolve.pred.taken != resolve.actual_taken) ||
                      (resolve.pred.taken && resolve.actual_taken &&
                       (resolve.pred.target != resolve.actual_target));

  assign corrected_pc = resolve.actual_taken ? resolve.actual_target
                                             : resolve.pred.pc + 16'd1;

  ////////////////////////////////////////
  // Table writes, same cycle as strobe
  ////////////////////////////////////////
  assign bht_we  = resolve_valid;
  assign bht_upd = '{pc: resolve.pred.pc, ctr: next_ctr};
  assign btb_we  = resolve_valid && resolve.actual_taken;
  assign btb_upd = '{pc: resolve.pred.pc, target: resolve.actual_target};

  // Redirect one cycle after the strobe.
  always_ff @(posedge clk) begin
    if (reset) begin
      redirect <= 1'b0;
    end else begin
      redirect <= resolve_valid && mispredict;
    end
  end

  always_ff @(posedge clk) begin
    redirect_pc <= corrected_pc;              // Payload, only meaningful with redirect.
  end

  a_redirect_follows_strobe: assert property (
    @(posedge clk) disable iff (reset)
    redirect |-> $past(resolve_valid)
  ) else $error("branch_resolve: redirect without a resolution");

endmodule

// ==== btb.sv ====
module btb
  import bp_pkg::*;
(
  input  logic     clk,                       // System clock.
  input  logic     reset,                     // Sync reset, active high.
  input  logic [pc_w-1:0] lookup_pc,          // Fetch PC to look up.
  input  logic     we,                        // Write strobe, taken branches only.
  input  btb_upd_t upd,                       // Branch PC and its target.
  output logic     hit,                       // Valid entry with matching tag.
  output logic [pc_w-1:0] target              // Stored target, zero on miss.
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  logic [n_entries-1:0] valid_q;              // Valid bits.
  logic [tag_w-1:0]     tag_q    [n_entries]; // Stored tags.
  logic [pc_w-1:0]      target_q [n_entries]; // Stored taken targets.

  logic [idx_w-1:0] rd_idx;                   // Lookup index.
  logic [idx_w-1:0] wr_idx;                   // Write index.

  assign rd_idx = lookup_pc[idx_w-1:0];
  assign wr_idx = upd.pc[idx_w-1:0];

  ////////////////////////////////////////
  // Read with tag compare
  ////////////////////////////////////////
  assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc[pc_w-1:idx_w]);
  assign target = hit ? target_q[rd_idx] : '0;  // Selector ignores it on a miss.

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;                          // Clear all entries.
    end else if (we) begin
      valid_q[wr_idx] <= 1'b1;                // Mark entry in use.
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      tag_q[wr_idx]    <= upd.pc[pc_w-1:idx_w];  // Evicts any alias.
      target_q[wr_idx] <= upd.target;            // Latest taken target wins.
    end
  end

endmodule

// ==== bht.sv ====
module bht
  import bp_pkg::*;
(
  input  logic     clk,                       // System clock.
  input  logic     reset,                     // Sync reset, active high.
  input  logic [pc_w-1:0] lookup_pc,          // Fetch PC to predict for.
  input  logic     we,                        // Update strobe.
  input  bht_upd_t upd,                       // Update PC and counter.
  output logic     hit,                       // Valid entry with matching tag.
  output counter_e ctr                        // Counter, or ctr_miss on a miss.
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  logic [n_entries-1:0] valid_q;              // One valid bit per entry.
  logic [tag_w-1:0]     tag_q [n_entries];    // Stored tags.
  counter_e             ctr_q [n_entries];    // Stored 2-bit counters.

  logic [idx_w-1:0] rd_idx;                   // Lookup index.
  logic [tag_w-1:0] rd_tag;                   // Lookup tag.
  logic [idx_w-1:0] upd_idx;                  // Update index.
  logic [tag_w-1:0] upd_tag;                  // Update tag.

  assign rd_idx  = lookup_pc[idx_w-1:0];
  assign rd_tag  = lookup_pc[pc_w-1:idx_w];
  assign upd_idx = upd.pc[idx_w-1:0];
  assign upd_tag = upd.pc[pc_w-1:idx_w];

  ////////////////////////////////////////
  // Read, latency 0
  ////////////////////////////////////////
  // Separate read port, so an update in flight never disturbs the lookup.
  assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign ctr = hit ? ctr_q[rd_idx] : ctr_miss;  // Miss looks weakly not taken.

  ////////////////////////////////////////
  // Write, latency 1
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;                          // Every entry invalid.
    end else if (we) begin
      valid_q[upd_idx] <= 1'b1;               // Entry now owned by upd tag.
    end
  end

  // An update to an occupied index simply evicts the old tag.
  always_ff @(posedge clk) begin
    if (we) begin
      tag_q[upd_idx] <= upd_tag;              // Replace tag.
      ctr_q[upd_idx] <= upd.ctr;              // New counter from resolve.
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Resolution must stay quiet while the tables are being cleared.
  a_no_we_in_reset: assert property (
    @(posedge clk) reset |-> !we
  ) else $error("bht: update strobe during reset");

  // A hitting entry holds one of the four counter states.
  a_ctr_legal: assert property (
    @(posedge clk) disable iff (reset)
    hit |-> (ctr inside {strong_nt, weak_nt, weak_t, strong_t})
  ) else $error("bht: stored counter outside the enum");

endmodule

// ==== bp_pkg.sv ====
package bp_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int pc_w      = 16;              // Word-address PC width.
  localparam int idx_w     = 4;               // Table index, PC bits 3..0.
  localparam int tag_w     = pc_w - idx_w;    // Tag, PC bits 15..4.
  localparam int n_entries = 1 << idx_w;      // Entries per table.

  ////////////////////////////////////////
  // Counter encoding
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    strong_nt = 2'd0,                         // Strongly not taken.
    weak_nt   = 2'd1,                         // Weakly not taken.
    weak_t    = 2'd2,                         // Weakly taken.
    strong_t  = 2'd3                          // Strongly taken.
  } counter_e;

  localparam counter_e ctr_miss = weak_nt;    // Reported on a BHT tag miss.

  ////////////////////////////////////////
  // Records
  ////////////////////////////////////////
  // Prediction carried from fetch to decode, 35 bits.
  typedef struct packed {
    logic [pc_w-1:0] pc;                      // PC that was looked up.
    counter_e        ctr;                     // Counter seen at lookup.
    logic            taken;                   // Predicted direction.
    logic [pc_w-1:0] target;                  // Predicted next PC.
  } fetch_pred_t;

  // Resolution returned by decode, 52 bits.
  typedef struct packed {
    fetch_pred_t     pred;                    // Record as it was predicted.
    logic            actual_taken;            // Real direction.
    logic [pc_w-1:0] actual_target;           // Real branch target.
  } resolve_t;

  typedef struct packed {
    logic [pc_w-1:0] pc;                      // Branch PC, gives index and tag.
    counter_e        ctr;                     // New counter value.
  } bht_upd_t;

  typedef struct packed {
    logic [pc_w-1:0] pc;                      // Branch PC, gives index and tag.
    logic [pc_w-1:0] target;                  // Taken target to remember.
  } btb_upd_t;

endpackage
